// ==== sources.f ====
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/wb_if.sv
hdl/fetch_stage.sv
hdl/stage_reg.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/core_top.sv
test/clock_gen.sv
test/core_chk.sv
test/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_top_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import pipe_pkg::*;

    localparam int          PROG_LEN       = 200;
    localparam int          RESET_CYCLES   = 16;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + 3 * PROG_LEN + 50;
    localparam int          TAIL_CYCLES    = 8;
    localparam logic [31:0] SEED           = 32'h9086_679a;
    // b with offset zero spins in place and writes nothing
    localparam word_t       SELF_LOOP      = 32'h5000_0000;

    typedef enum int {
        K_ADD, K_SUB, K_SLT, K_SLTU, K_NOR, K_AND, K_OR, K_XOR, K_SLL, K_SRL, K_SRA,
        K_SLLI, K_SRLI, K_SRAI,
        K_SLTI, K_SLTUI, K_ADDI, K_ANDI, K_ORI, K_XORI,
        K_LU12I, K_PCADDU12I,
        K_BEQ, K_BNE, K_B, K_BL, K_JIRL
    } kind_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t wnum;
        word_t     data;
    } trace_t;

    logic        clk;
    logic        reset;
    word_t       inst_sram_addr;
    word_t       inst_sram_rdata;
    word_t       debug_wb_pc;
    logic        debug_wb_rf_we;
    reg_addr_t   debug_wb_rf_wnum;
    word_t       debug_wb_rf_wdata;

    // program kept as fields, encoded words in prog
    kind_t       kind  [PROG_LEN];
    reg_addr_t   f_rd  [PROG_LEN];
    reg_addr_t   f_rj  [PROG_LEN];
    reg_addr_t   f_rk  [PROG_LEN];
    logic [25:0] f_imm [PROG_LEN];
    word_t       prog  [PROG_LEN];
    trace_t      expected [$];
    word_t       addr_hold;
    int          value_errors;
    int          other_errors;
    int          cycles;

    clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    core_top dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    bind core_top core_chk u_chk (
        .clk            (clk),
        .reset          (reset),
        .inst_sram_addr (inst_sram_addr),
        .debug_wb_rf_we (debug_wb_rf_we)
    );

    // opcode bits of each instruction with all fields zero
    function automatic word_t base_of(kind_t k);
        case (k)
            K_ADD:       return 32'h0010_0000;
            K_SUB:       return 32'h0011_0000;
            K_SLT:       return 32'h0012_0000;
            K_SLTU:      return 32'h0012_8000;
            K_NOR:       return 32'h0014_0000;
            K_AND:       return 32'h0014_8000;
            K_OR:        return 32'h0015_0000;
            K_XOR:       return 32'h0015_8000;
            K_SLL:       return 32'h0017_0000;
            K_SRL:       return 32'h0017_8000;
            K_SRA:       return 32'h0018_0000;
            K_SLLI:      return 32'h0040_8000;
            K_SRLI:      return 32'h0044_8000;
            K_SRAI:      return 32'h0048_8000;
            K_SLTI:      return 32'h0200_0000;
            K_SLTUI:     return 32'h0240_0000;
            K_ADDI:      return 32'h0280_0000;
            K_ANDI:      return 32'h0340_0000;
            K_ORI:       return 32'h0380_0000;
            K_XORI:      return 32'h03c0_0000;
            K_LU12I:     return 32'h1400_0000;
            K_PCADDU12I: return 32'h1c00_0000;
            K_BEQ:       return 32'h5800_0000;
            K_BNE:       return 32'h5c00_0000;
            K_B:         return 32'h5000_0000;
            K_BL:        return 32'h5400_0000;
            default:     return 32'h4c00_0000;
        endcase
    endfunction

    function automatic word_t encode(int i);
        word_t w;
        w = base_of(kind[i]);
        if (kind[i] <= K_SRA) begin
            w = w | {17'b0, f_rk[i], f_rj[i], f_rd[i]};
        end else if (kind[i] == K_LU12I || kind[i] == K_PCADDU12I) begin
            w = w | {7'b0, f_imm[i][19:0], f_rd[i]};
        end else if (kind[i] == K_B || kind[i] == K_BL) begin
            // offs26 split, low half above the high half
            w = w | {6'b0, f_imm[i][15:0], f_imm[i][25:16]};
        end else begin
            w = w | {6'b0, f_imm[i][15:0], f_rj[i], f_rd[i]};
        end
        return w;
    endfunction

    function automatic word_t alu_ref(kind_t k, word_t a, word_t b);
        case (k)
            K_ADD, K_ADDI:   return a + b;
            K_SUB:           return a - b;
            K_SLT, K_SLTI:   return {31'b0, $signed(a) < $signed(b)};
            K_SLTU, K_SLTUI: return {31'b0, a < b};
            K_NOR:           return ~(a | b);
            K_AND, K_ANDI:   return a & b;
            K_OR, K_ORI:     return a | b;
            K_XOR, K_XORI:   return a ^ b;
            K_SLL, K_SLLI:   return a << b[4:0];
            K_SRL, K_SRLI:   return a >> b[4:0];
            default:         return $signed(a) >>> b[4:0];
        endcase
    endfunction

    // forward target, never onto a jirl whose base was not just computed
    function automatic int pick_target(int first);
        int t;
        t = first + int'($urandom % 8);
        if (t > PROG_LEN - 1) begin
            t = PROG_LEN - 1;
        end
        if (kind[t] == K_JIRL) begin
            t = t - 1;
        end
        return t;
    endfunction

    task automatic build_program();
        int i;
        int t;
        int pick;
        i = 0;
        while (i < PROG_LEN) begin
            pick = int'($urandom % 100);
            if (i < 7) begin
                kind[i] = K_ADDI;
            end else if (pick < 6 && i <= PROG_LEN - 3) begin
                kind[i] = K_PCADDU12I;
                kind[i + 1] = K_JIRL;
                i++;
            end else if (pick < 22 && i <= PROG_LEN - 2) begin
                kind[i] = kind_t'(int'(K_BEQ) + int'($urandom % 4));
            end else begin
                kind[i] = kind_t'(int'($urandom % 22));
            end
            i++;
        end
        for (int k = 0; k < PROG_LEN; k++) begin
            // small register pool keeps dependency chains dense
            f_rd[k]  = reg_addr_t'($urandom % 8);
            f_rj[k]  = reg_addr_t'($urandom % 8);
            f_rk[k]  = reg_addr_t'($urandom % 8);
            f_imm[k] = 26'($urandom);
            if (k < 7) begin
                f_rd[k]  = reg_addr_t'(k + 1);
                f_rj[k]  = '0;
                f_imm[k] = {14'b0, f_imm[k][11:0]};
            end else if (kind[k] <= K_SRA) begin
                f_imm[k] = '0;
            end else if (kind[k] <= K_SRAI) begin
                f_imm[k] = {21'b0, f_imm[k][4:0]};
            end else if (kind[k] <= K_XORI) begin
                f_imm[k] = {14'b0, f_imm[k][11:0]};
            end else if (kind[k] <= K_PCADDU12I) begin
                f_imm[k] = {6'b0, f_imm[k][19:0]};
                if (k + 1 < PROG_LEN && kind[k + 1] == K_JIRL) begin
                    f_rd[k]  = 5'd30;
                    f_imm[k] = '0;
                end
            end else if (kind[k] == K_JIRL) begin
                // r30 holds the pc of the pcaddu12i before it
                f_rj[k]  = 5'd30;
                t        = pick_target(k + 1);
                f_imm[k] = 26'(t - (k - 1));
            end else begin
                t        = pick_target(k + 1);
                f_imm[k] = 26'(t - k);
                if ($urandom % 3 == 0) begin
                    f_rd[k] = f_rj[k];
                end
            end
            prog[k] = encode(k);
        end
    endtask

    // walks the program in commit order and queues every register write
    task automatic run_model();
        word_t     regs [32];
        word_t     pc;
        word_t     src2;
        word_t     result;
        word_t     target;
        int        idx;
        logic      writes;
        reg_addr_t dest;
        trace_t    entry;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        idx = 0;
        while (idx < PROG_LEN) begin
            pc     = RESET_PC + word_t'(idx << 2);
            target = pc + 32'd4;
            writes = 1'b1;
            dest   = f_rd[idx];
            result = '0;
            if (kind[idx] <= K_SRA) begin
                result = alu_ref(kind[idx], regs[f_rj[idx]], regs[f_rk[idx]]);
            end else if (kind[idx] <= K_SRAI) begin
                src2   = {27'b0, f_imm[idx][4:0]};
                result = alu_ref(kind[idx], regs[f_rj[idx]], src2);
            end else if (kind[idx] <= K_ADDI) begin
                src2   = {{20{f_imm[idx][11]}}, f_imm[idx][11:0]};
                result = alu_ref(kind[idx], regs[f_rj[idx]], src2);
            end else if (kind[idx] <= K_XORI) begin
                src2   = {20'b0, f_imm[idx][11:0]};
                result = alu_ref(kind[idx], regs[f_rj[idx]], src2);
            end else begin
                case (kind[idx])
                    K_LU12I: begin
                        result = {f_imm[idx][19:0], 12'b0};
                    end
                    K_PCADDU12I: begin
                        result = pc + {f_imm[idx][19:0], 12'b0};
                    end
                    K_BEQ, K_BNE: begin
                        writes = 1'b0;
                        if ((regs[f_rj[idx]] == regs[f_rd[idx]]) == (kind[idx] == K_BEQ)) begin
                            target = pc + {{14{f_imm[idx][15]}}, f_imm[idx][15:0], 2'b0};
                        end
                    end
                    K_B: begin
                        writes = 1'b0;
                        target = pc + {{4{f_imm[idx][25]}}, f_imm[idx], 2'b0};
                    end
                    K_BL: begin
                        result = pc + 32'd4;
                        dest   = 5'd1;
                        target = pc + {{4{f_imm[idx][25]}}, f_imm[idx], 2'b0};
                    end
                    default: begin
                        result = pc + 32'd4;
                        target = regs[f_rj[idx]] + {{14{f_imm[idx][15]}}, f_imm[idx][15:0], 2'b0};
                    end
                endcase
            end
            if (writes) begin
                entry.pc   = pc;
                entry.wnum = dest;
                entry.data = result;
                expected.push_back(entry);
                // r0 shows up on the trace but keeps reading zero
                if (dest != 5'd0) begin
                    regs[dest] = result;
                end
            end
            idx = int'((target - RESET_PC) >> 2);
        end
    endtask

    function automatic word_t fetch_word(word_t addr);
        word_t offs;
        int    idx;
        offs = addr - RESET_PC;
        if ($isunknown(addr) || addr < RESET_PC || offs >= word_t'(PROG_LEN * 4)) begin
            return SELF_LOOP;
        end
        idx = int'(offs >> 2);
        return prog[idx];
    endfunction

    task automatic check_value(string name, word_t got, word_t want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
            value_errors++;
        end
    endtask

    // address is settled by mid cycle
    always @(negedge clk) begin
        addr_hold <= inst_sram_addr;
    end

    // synchronous instruction memory, word appears one edge later
    initial begin
        inst_sram_rdata = SELF_LOOP;
        forever begin
            @(posedge clk);
            #1 inst_sram_rdata = fetch_word(addr_hold);
        end
    end

    always @(negedge clk) begin
        trace_t want;
        if (!reset && debug_wb_rf_we) begin
            if (expected.size() == 0) begin
                $display("unexpected register write at pc %h to r%0d with nothing left to retire",
                         debug_wb_pc, debug_wb_rf_wnum);
                other_errors++;
            end else begin
                want = expected.pop_front();
                check_value("debug_wb_pc", debug_wb_pc, want.pc);
                check_value("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum), word_t'(want.wnum));
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, want.data);
            end
        end
    end

    initial begin
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        void'($urandom(SEED));
        build_program();
        run_model();
        while (expected.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (expected.size() != 0) begin
            $display("timeout after %0d cycles with %0d register writes still missing",
                     cycles, expected.size());
            other_errors++;
        end else begin
            // a few more cycles to catch stray writes past the end
            repeat (TAIL_CYCLES) @(posedge clk);
        end
        other_errors = other_errors + dut.u_chk.fail_count;
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== test/core_chk.sv ====
`timescale 1ns/1ps

module core_chk (
    input logic                      clk,
    input logic                      reset,
    input logic [pipe_pkg::XLEN-1:0] inst_sram_addr,
    input logic                      debug_wb_rf_we
);
    import pipe_pkg::*;

    int fail_count = 0;

    // wb register has been cleared once reset was seen on an edge
    no_write_in_reset: assert property (
        @(posedge clk) reset && $past(reset) |-> !debug_wb_rf_we
    ) else begin
        fail_count++;
        $error("trace write enable high while reset is asserted");
    end

    addr_aligned: assert property (
        @(posedge clk) disable iff (reset) inst_sram_addr[1:0] == 2'b00
    ) else begin
        fail_count++;
        $error("instruction fetch address %h is not word aligned", inst_sram_addr);
    end

    // first fetch out of reset is the reset vector
    first_fetch: assert property (
        @(posedge clk) $fell(reset) |-> inst_sram_addr == RESET_PC
    ) else begin
        fail_count++;
        $error("first fetch after reset went to %h", inst_sram_addr);
    end

endmodule

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // released just after an edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== hdl/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic                          clk,
    input  logic                          reset,
    output logic [pipe_pkg::XLEN-1:0]     inst_sram_addr,
    input  logic [pipe_pkg::XLEN-1:0]     inst_sram_rdata,
    output logic [pipe_pkg::XLEN-1:0]     debug_wb_pc,
    output logic                          debug_wb_rf_we,
    output logic [pipe_pkg::REG_AW-1:0]   debug_wb_rf_wnum,
    output logic [pipe_pkg::XLEN-1:0]     debug_wb_rf_wdata
);
    import pipe_pkg::*;

    logic   br_taken;
    word_t  br_target;
    logic   fetch_valid;
    word_t  fetch_pc;
    if_id_t fetch_item;
    logic   id_valid;
    if_id_t id_item;
    logic   dec_valid;
    id_ex_t dec_item;
    logic   ex_valid;
    id_ex_t ex_item;

    wb_if ex_fwd ();
    wb_if wb ();

    fetch_stage u_fetch (
        .clk        (clk),
        .reset      (reset),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .fetch_addr (inst_sram_addr),
        .out_valid  (fetch_valid),
        .out_pc     (fetch_pc)
    );

    // memory word pairs with the pc fetch held for it
    assign fetch_item = '{pc: fetch_pc, inst: inst_sram_rdata};

    // taken branch kills both younger slots
    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk       (clk),
        .reset     (reset),
        .flush     (br_taken),
        .in_valid  (fetch_valid),
        .in_data   (fetch_item),
        .out_valid (id_valid),
        .out_data  (id_item)
    );

    decode_stage u_decode (
        .clk       (clk),
        .in_valid  (id_valid),
        .in_data   (id_item),
        .ex_fwd    (ex_fwd),
        .wb        (wb),
        .out_valid (dec_valid),
        .out_data  (dec_item)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .reset     (reset),
        .flush     (br_taken),
        .in_valid  (dec_valid),
        .in_data   (dec_item),
        .out_valid (ex_valid),
        .out_data  (ex_item)
    );

    execute_stage u_execute (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ex_valid),
        .in_data   (ex_item),
        .br_taken  (br_taken),
        .br_target (br_target),
        .ex_fwd    (ex_fwd),
        .wb        (wb)
    );

    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_we    = wb.we;
    assign debug_wb_rf_wnum  = wb.dest;
    assign debug_wb_rf_wdata = wb.data;

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  pipe_pkg::id_ex_t in_data,
    output logic             br_taken,
    output pipe_pkg::word_t  br_target,
    wb_if.source             ex_fwd,
    wb_if.source             wb
);
    import pipe_pkg::*;
    import isa_pkg::*;

    word_t      src1;
    word_t      src2;
    logic [4:0] shamt;
    word_t      alu_result;
    logic       rj_eq_rd;
    logic       br_cond;
    logic       fwd_we;

    assign src1  = in_data.src1_is_pc ? in_data.pc : in_data.rj_value;
    assign src2  = in_data.src2_is_imm ? in_data.imm : in_data.rkd_value;
    // shifts use the low five bits only
    assign shamt = src2[4:0];

    always_comb begin
        case (in_data.alu_op)
            ALU_ADD:  alu_result = src1 + src2;
            ALU_SUB:  alu_result = src1 - src2;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, src1 < src2};
            ALU_AND:  alu_result = src1 & src2;
            ALU_NOR:  alu_result = ~(src1 | src2);
            ALU_OR:   alu_result = src1 | src2;
            ALU_XOR:  alu_result = src1 ^ src2;
            ALU_SLL:  alu_result = src1 << shamt;
            ALU_SRL:  alu_result = src1 >> shamt;
            ALU_SRA:  alu_result = $signed(src1) >>> shamt;
            ALU_LUI:  alu_result = src2;
            default:  alu_result = '0;
        endcase
    end

    assign rj_eq_rd = in_data.rj_value == in_data.rkd_value;

    always_comb begin
        case (in_data.br_kind)
            BR_BEQ:  br_cond = rj_eq_rd;
            BR_BNE:  br_cond = !rj_eq_rd;
            BR_B,
            BR_BL,
            BR_JIRL: br_cond = 1'b1;
            default: br_cond = 1'b0;
        endcase
    end

    assign br_taken  = in_valid && br_cond;
    // jirl is register relative, the rest pc relative
    assign br_target = (in_data.br_kind == BR_JIRL ? in_data.rj_value : in_data.pc) +
                       in_data.br_offs;

    assign fwd_we      = in_valid && in_data.gr_we;
    assign ex_fwd.we   = fwd_we;
    assign ex_fwd.dest = in_data.dest;
    assign ex_fwd.data = alu_result;
    assign ex_fwd.pc   = in_data.pc;

    // writeback register, also the trace
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.we <= 1'b0;
        end else begin
            wb.we <= fwd_we;
        end
    end

    always_ff @(posedge clk) begin
        wb.dest <= in_data.dest;
        wb.data <= alu_result;
        wb.pc   <= in_data.pc;
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic             clk,
    input  logic             in_valid,
    input  pipe_pkg::if_id_t in_data,
    wb_if.sink               ex_fwd,
    wb_if.sink               wb,
    output logic             out_valid,
    output pipe_pkg::id_ex_t out_data
);
    import pipe_pkg::*;
    import isa_pkg::*;

    word_t       inst;
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    reg_addr_t   raddr2;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    alu_op_t     op17_alu;
    alu_op_t     op10_alu;
    alu_op_t     alu_op;
    br_kind_t    br_kind;
    logic        op17_hit;
    logic        op10_hit;
    logic        shift_imm;
    logic        inst_lu12i;
    logic        inst_pcaddu12i;
    logic        is_link;
    logic        need_ui12;
    logic        need_si20;
    logic        src2_is_imm;
    logic        src1_is_pc;
    logic        gr_we;
    word_t       imm;
    word_t       br_offs;
    word_t       rf_rdata1;
    word_t       rf_rdata2;
    word_t       rj_value;
    word_t       rkd_value;

    assign inst = in_data.inst;
    assign op17 = inst[OP17_LSB +: 17];
    assign op10 = inst[OP10_LSB +: 10];
    assign op7  = inst[OP7_LSB +: 7];
    assign op6  = inst[OP6_LSB +: 6];
    assign rd   = inst[RD_LSB +: REG_AW];
    assign rj   = inst[RJ_LSB +: REG_AW];
    assign rk   = inst[RK_LSB +: REG_AW];
    assign i12  = inst[I12_LSB +: 12];
    assign i16  = inst[I16_LSB +: 16];
    assign i20  = inst[I20_LSB +: 20];
    assign i26  = {inst[I26_HI_LSB +: 10], inst[I26_LO_LSB +: 16]};

    // three-register ops and shift immediates
    always_comb begin
        op17_alu = ALU_ADD;
        op17_hit = 1'b1;
        case (op17)
            OPC_ADD_W:  op17_alu = ALU_ADD;
            OPC_SUB_W:  op17_alu = ALU_SUB;
            OPC_SLT:    op17_alu = ALU_SLT;
            OPC_SLTU:   op17_alu = ALU_SLTU;
            OPC_NOR:    op17_alu = ALU_NOR;
            OPC_AND:    op17_alu = ALU_AND;
            OPC_OR:     op17_alu = ALU_OR;
            OPC_XOR:    op17_alu = ALU_XOR;
            OPC_SLL_W:  op17_alu = ALU_SLL;
            OPC_SRL_W:  op17_alu = ALU_SRL;
            OPC_SRA_W:  op17_alu = ALU_SRA;
            OPC_SLLI_W: op17_alu = ALU_SLL;
            OPC_SRLI_W: op17_alu = ALU_SRL;
            OPC_SRAI_W: op17_alu = ALU_SRA;
            default:    op17_hit = 1'b0;
        endcase
    end

    // 12-bit immediate ops
    always_comb begin
        op10_alu = ALU_ADD;
        op10_hit = 1'b1;
        case (op10)
            OPC_ADDI_W: op10_alu = ALU_ADD;
            OPC_SLTI:   op10_alu = ALU_SLT;
            OPC_SLTUI:  op10_alu = ALU_SLTU;
            OPC_ANDI:   op10_alu = ALU_AND;
            OPC_ORI:    op10_alu = ALU_OR;
            OPC_XORI:   op10_alu = ALU_XOR;
            default:    op10_hit = 1'b0;
        endcase
    end

    always_comb begin
        case (op6)
            OPC_BEQ:  br_kind = BR_BEQ;
            OPC_BNE:  br_kind = BR_BNE;
            OPC_B:    br_kind = BR_B;
            OPC_BL:   br_kind = BR_BL;
            OPC_JIRL: br_kind = BR_JIRL;
            default:  br_kind = BR_NONE;
        endcase
    end

    assign shift_imm      = op17 == OPC_SLLI_W || op17 == OPC_SRLI_W || op17 == OPC_SRAI_W;
    assign inst_lu12i     = op7 == OPC_LU12I_W;
    assign inst_pcaddu12i = op7 == OPC_PCADDU12I;
    assign is_link        = br_kind == BR_BL || br_kind == BR_JIRL;
    assign need_ui12      = op10 == OPC_ANDI || op10 == OPC_ORI || op10 == OPC_XORI;
    assign need_si20      = inst_lu12i || inst_pcaddu12i;

    // link and pcaddu12i go through the adder, unknown encodings write nothing
    assign alu_op      = op17_hit ? op17_alu : op10_hit ? op10_alu : inst_lu12i ? ALU_LUI : ALU_ADD;
    assign src1_is_pc  = inst_pcaddu12i || is_link;
    assign src2_is_imm = shift_imm || op10_hit || need_si20 || is_link;
    assign gr_we       = op17_hit || op10_hit || need_si20 || is_link;

    assign imm = is_link   ? 32'd4 :
                 need_si20 ? {i20, 12'b0} :
                 need_ui12 ? {20'b0, i12} :
                             {{20{i12[11]}}, i12};

    assign br_offs = (br_kind == BR_B || br_kind == BR_BL) ? {{4{i26[25]}}, i26, 2'b0} :
                                                             {{14{i16[15]}}, i16, 2'b0};

    // beq and bne compare rj against rd
    assign raddr2 = (br_kind == BR_BEQ || br_kind == BR_BNE) ? rd : rk;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rf_rdata1),
        .raddr2 (raddr2),
        .rdata2 (rf_rdata2),
        .wb     (wb)
    );

    // youngest producer wins, r0 never forwarded
    assign rj_value = (ex_fwd.we && ex_fwd.dest == rj && rj != '0) ? ex_fwd.data :
                      (wb.we && wb.dest == rj && rj != '0)         ? wb.data :
                                                                     rf_rdata1;
    assign rkd_value = (ex_fwd.we && ex_fwd.dest == raddr2 && raddr2 != '0) ? ex_fwd.data :
                       (wb.we && wb.dest == raddr2 && raddr2 != '0)         ? wb.data :
                                                                              rf_rdata2;

    assign out_valid = in_valid;

    always_comb begin
        out_data.pc          = in_data.pc;
        out_data.alu_op      = alu_op;
        out_data.br_kind     = br_kind;
        out_data.src1_is_pc  = src1_is_pc;
        out_data.src2_is_imm = src2_is_imm;
        out_data.imm         = imm;
        out_data.br_offs     = br_offs;
        out_data.rj_value    = rj_value;
        out_data.rkd_value   = rkd_value;
        out_data.gr_we       = gr_we;
        out_data.dest        = (br_kind == BR_BL) ? LINK_REG : rd;
    end

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  pipe_pkg::reg_addr_t raddr1,
    output pipe_pkg::word_t     rdata1,
    input  pipe_pkg::reg_addr_t raddr2,
    output pipe_pkg::word_t     rdata2,
    wb_if.sink                  wb
);
    import pipe_pkg::*;

    word_t regs [2**REG_AW];

    always_ff @(posedge clk) begin
        if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // r0 is hardwired, whatever was written there
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hdl/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload moves along with its valid bit
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            br_taken,
    input  pipe_pkg::word_t br_target,
    output pipe_pkg::word_t fetch_addr,
    output logic            out_valid,
    output pipe_pkg::word_t out_pc
);
    import pipe_pkg::*;

    // address presented to memory last cycle
    word_t pc;

    // one word before the reset vector, so fetch_addr is RESET_PC during reset
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= RESET_PC - INST_BYTES;
            out_valid <= 1'b0;
        end else begin
            pc        <= fetch_addr;
            out_valid <= 1'b1;
        end
    end

    assign fetch_addr = br_taken ? br_target : pc + INST_BYTES;

    // word for this pc is now on the read data port
    assign out_pc = pc;

endmodule

// ==== hdl/wb_if.sv ====
`timescale 1ns/1ps

// register write bus, we already qualified by valid
interface wb_if ();
    import pipe_pkg::*;

    logic      we;
    reg_addr_t dest;
    word_t     data;
    word_t     pc;

    modport source (output we, dest, data, pc);
    modport sink   (input we, dest, data, pc);

endinterface

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    localparam word_t     RESET_PC   = 32'h1c00_0000;
    localparam word_t     INST_BYTES = 32'd4;
    localparam reg_addr_t LINK_REG   = 5'd1;

    // fetch to decode
    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    // decode to execute
    typedef struct packed {
        word_t              pc;
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::br_kind_t  br_kind;
        logic               src1_is_pc;
        logic               src2_is_imm;
        word_t              imm;
        word_t              br_offs;
        word_t              rj_value;
        word_t              rkd_value;
        logic               gr_we;
        reg_addr_t          dest;
    } id_ex_t;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    // alu operations after decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_kind_t;

    // low bit of each opcode slice
    localparam int OP17_LSB = 15;
    localparam int OP10_LSB = 22;
    localparam int OP7_LSB  = 25;
    localparam int OP6_LSB  = 26;

    // operand and immediate fields
    localparam int RD_LSB     = 0;
    localparam int RJ_LSB     = 5;
    localparam int RK_LSB     = 10;
    localparam int I12_LSB    = 10;
    localparam int I16_LSB    = 10;
    localparam int I20_LSB    = 5;
    localparam int I26_LO_LSB = 10;
    localparam int I26_HI_LSB = 0;

    // {31:26, 25:22, 21:20, 19:15}
    localparam logic [16:0] OPC_ADD_W  = {6'h00, 4'h0, 2'h1, 5'h00};
    localparam logic [16:0] OPC_SUB_W  = {6'h00, 4'h0, 2'h1, 5'h02};
    localparam logic [16:0] OPC_SLT    = {6'h00, 4'h0, 2'h1, 5'h04};
    localparam logic [16:0] OPC_SLTU   = {6'h00, 4'h0, 2'h1, 5'h05};
    localparam logic [16:0] OPC_NOR    = {6'h00, 4'h0, 2'h1, 5'h08};
    localparam logic [16:0] OPC_AND    = {6'h00, 4'h0, 2'h1, 5'h09};
    localparam logic [16:0] OPC_OR     = {6'h00, 4'h0, 2'h1, 5'h0a};
    localparam logic [16:0] OPC_XOR    = {6'h00, 4'h0, 2'h1, 5'h0b};
    localparam logic [16:0] OPC_SLL_W  = {6'h00, 4'h0, 2'h1, 5'h0e};
    localparam logic [16:0] OPC_SRL_W  = {6'h00, 4'h0, 2'h1, 5'h0f};
    localparam logic [16:0] OPC_SRA_W  = {6'h00, 4'h0, 2'h1, 5'h10};
    localparam logic [16:0] OPC_SLLI_W = {6'h00, 4'h1, 2'h0, 5'h01};
    localparam logic [16:0] OPC_SRLI_W = {6'h00, 4'h1, 2'h0, 5'h09};
    localparam logic [16:0] OPC_SRAI_W = {6'h00, 4'h1, 2'h0, 5'h11};

    // {31:26, 25:22}
    localparam logic [9:0] OPC_SLTI   = {6'h00, 4'h8};
    localparam logic [9:0] OPC_SLTUI  = {6'h00, 4'h9};
    localparam logic [9:0] OPC_ADDI_W = {6'h00, 4'ha};
    localparam logic [9:0] OPC_ANDI   = {6'h00, 4'hd};
    localparam logic [9:0] OPC_ORI    = {6'h00, 4'he};
    localparam logic [9:0] OPC_XORI   = {6'h00, 4'hf};

    // {31:26, 25}
    localparam logic [6:0] OPC_LU12I_W    = {6'h05, 1'b0};
    localparam logic [6:0] OPC_PCADDU12I = {6'h07, 1'b0};

    // 31:26 only
    localparam logic [5:0] OPC_JIRL = 6'h13;
    localparam logic [5:0] OPC_B    = 6'h14;
    localparam logic [5:0] OPC_BL   = 6'h15;
    localparam logic [5:0] OPC_BEQ  = 6'h16;
    localparam logic [5:0] OPC_BNE  = 6'h17;

endpackage
